/* common/udp_rx_settings.svh */
// byte offsets sit in a 12-bit AXI space and the payload window base must align to its size
`ifndef UDP_RX_SETTINGS_SVH
`define UDP_RX_SETTINGS_SVH

// 256 words hold 1024 payload bytes
`define UDP_BUF_WORDS 256
`define ETH_TYPE_IPV4 16'h0800

// bit 0 valid, bits 31:16 byte count
`define REG_STATUS    12'h000
// write 1 to free the buffer
`define REG_RELEASE   12'h004
// 16-bit saturating count
`define REG_DROPS     12'h008
// word n of the buffer at base + 4*n
`define PAYLOAD_BASE  12'h400

`define AXIL_ADDR_W   12

`endif

/* common/udp_rx_pkg.sv */
// buffer address width follows UDP_BUF_WORDS, and the state enum is also shown by the testbench
`default_nettype none
`include "udp_rx_settings.svh"

package udp_rx_pkg;

    typedef logic [47:0] mac_t;      // ethernet address
    typedef logic [31:0] ip4_t;
    typedef logic [31:0] word_t;     // buffer and AXI data word
    typedef logic [15:0] byte_cnt_t; // payload length in bytes

    typedef logic [$clog2(`UDP_BUF_WORDS)-1:0] buf_addr_t;

    typedef enum logic [2:0] {
        idle,
        preamble,
        eth_head,
        ip_head,
        udp_head,
        rx_data,
        rx_end
    } rx_state_t;

endpackage

`default_nettype wire

/* udp_rx/udp_rx_parser.sv */
// needs gapless GMII bytes inside a frame, checks no FCS or IP checksum, stores at most 1024 bytes
`default_nettype none
`include "udp_rx_settings.svh"

module udp_rx_parser (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        gmii_rxdv,
    input  wire [7:0]                  gmii_rxd,
    input  wire udp_rx_pkg::mac_t      local_mac,
    input  wire udp_rx_pkg::ip4_t      local_ip,
    input  wire                        buf_held,
    output logic                       wr_req,
    output udp_rx_pkg::buf_addr_t      wr_addr,
    output udp_rx_pkg::word_t          wr_data,
    output logic                       pkt_done,
    output logic                       pkt_drop,
    output udp_rx_pkg::byte_cnt_t      pkt_bytes
);

    udp_rx_pkg::rx_state_t state;
    logic [5:0]            cnt;      // byte index inside the current header
    udp_rx_pkg::mac_t      dst_mac;
    logic [7:0]            type_hi;
    logic [3:0]            ihl;      // IP header length in 32-bit words
    udp_rx_pkg::ip4_t      dst_ip;
    udp_rx_pkg::byte_cnt_t udp_len;
    udp_rx_pkg::byte_cnt_t data_len;
    udp_rx_pkg::byte_cnt_t data_cnt;
    logic                  store;    // buffer was free at frame start
    logic                  mac_ok;
    logic                  last_byte;
    logic                  in_buf;

    assign mac_ok    = (dst_mac == local_mac) || (dst_mac == 48'hffff_ffff_ffff);
    assign last_byte = (data_cnt == data_len - 16'd1);
    assign in_buf    = (data_cnt < `UDP_BUF_WORDS * 4); // beyond this only counted

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= udp_rx_pkg::idle;
            cnt       <= '0;
            dst_mac   <= '0;
            type_hi   <= '0;
            ihl       <= '0;
            dst_ip    <= '0;
            udp_len   <= '0;
            data_len  <= '0;
            data_cnt  <= '0;
            store     <= 1'b0;
            wr_req    <= 1'b0;
            wr_addr   <= '0;
            wr_data   <= '0;
            pkt_done  <= 1'b0;
            pkt_drop  <= 1'b0;
            pkt_bytes <= '0;
        end else begin
            wr_req   <= 1'b0;
            pkt_done <= 1'b0;
            pkt_drop <= 1'b0;
            if (!gmii_rxdv) begin
                state <= udp_rx_pkg::idle; // frame over or cut short
                cnt   <= '0;
            end else begin
                cnt <= cnt + 6'd1;
                case (state)
                    udp_rx_pkg::idle: begin
                        cnt   <= '0;
                        store <= !buf_held;
                        if (gmii_rxd == 8'h55) begin
                            state <= udp_rx_pkg::preamble;
                        end else begin
                            state <= udp_rx_pkg::rx_end; // joined mid-frame
                        end
                    end
                    udp_rx_pkg::preamble: begin
                        if (cnt == 6'd6) begin
                            cnt   <= '0;
                            state <= (gmii_rxd == 8'hd5) ? udp_rx_pkg::eth_head
                                                         : udp_rx_pkg::rx_end;
                        end else if (gmii_rxd != 8'h55) begin
                            state <= udp_rx_pkg::rx_end;
                        end
                    end
                    udp_rx_pkg::eth_head: begin
                        if (cnt < 6'd6) begin
                            dst_mac <= {dst_mac[39:0], gmii_rxd};
                        end
                        if (cnt == 6'd12) begin
                            type_hi <= gmii_rxd;
                        end
                        if (cnt == 6'd13) begin
                            cnt <= '0;
                            if (mac_ok && {type_hi, gmii_rxd} == `ETH_TYPE_IPV4) begin
                                state <= udp_rx_pkg::ip_head;
                            end else begin
                                state <= udp_rx_pkg::rx_end;
                            end
                        end
                    end
                    udp_rx_pkg::ip_head: begin
                        if (cnt == 6'd0) begin
                            ihl <= gmii_rxd[3:0];
                            if (gmii_rxd[3:0] < 4'd5) begin
                                state <= udp_rx_pkg::rx_end; // malformed header
                            end
                        end
                        if (cnt >= 6'd16 && cnt <= 6'd19) begin
                            dst_ip <= {dst_ip[23:0], gmii_rxd};
                        end
                        if (cnt == 6'd19 && {dst_ip[23:0], gmii_rxd} != local_ip) begin
                            state <= udp_rx_pkg::rx_end;
                        end else if (cnt >= 6'd19 && cnt == {ihl, 2'b00} - 6'd1) begin
                            cnt   <= '0;              // options skipped by length
                            state <= udp_rx_pkg::udp_head;
                        end
                    end
                    udp_rx_pkg::udp_head: begin
                        if (cnt == 6'd4) begin
                            udp_len[15:8] <= gmii_rxd;
                        end
                        if (cnt == 6'd5) begin
                            udp_len[7:0] <= gmii_rxd;
                        end
                        if (cnt == 6'd7) begin
                            data_len <= udp_len - 16'd8;
                            data_cnt <= '0;
                            state    <= (udp_len > 16'd8) ? udp_rx_pkg::rx_data
                                                          : udp_rx_pkg::rx_end;
                        end
                    end
                    udp_rx_pkg::rx_data: begin
                        data_cnt <= data_cnt + 16'd1;
                        wr_addr  <= data_cnt[2 +: $bits(udp_rx_pkg::buf_addr_t)];
                        if (data_cnt[1:0] == 2'd0) begin
                            wr_data <= {gmii_rxd, 24'd0}; // low lanes zeroed for short tail
                        end else begin
                            wr_data[31 - 8 * data_cnt[1:0] -: 8] <= gmii_rxd;
                        end
                        wr_req <= store && in_buf && (data_cnt[1:0] == 2'd3 || last_byte);
                        if (last_byte) begin
                            pkt_done  <= store;
                            pkt_drop  <= !store;
                            pkt_bytes <= data_len;
                            state     <= udp_rx_pkg::rx_end;
                        end
                    end
                    udp_rx_pkg::rx_end: ; // wait for gmii_rxdv to fall
                    default: state <= udp_rx_pkg::idle;
                endcase
            end
        end
    end

    // the held buffer is never overwritten
    a_no_write_when_held: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req |-> !buf_held);

    a_done_when_free: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_done |-> !buf_held);

endmodule

`default_nettype wire

/* logic/buf_arbiter.sv */
// a read is granted only in a cycle without a parser write, and rd_req must stay high until rd_ack
`default_nettype none

module buf_arbiter (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        wr_req,
    input  wire udp_rx_pkg::buf_addr_t wr_addr,
    input  wire udp_rx_pkg::word_t     wr_data,
    input  wire                        rd_req,
    input  wire udp_rx_pkg::buf_addr_t rd_addr,
    input  wire udp_rx_pkg::word_t     ram_rdata,
    output logic                       ram_en,
    output logic                       ram_we,
    output udp_rx_pkg::buf_addr_t      ram_addr,
    output udp_rx_pkg::word_t          ram_wdata,
    output logic                       rd_ack,
    output udp_rx_pkg::word_t          rd_data
);

    logic rd_grant;

    assign rd_grant  = rd_req && !wr_req && !rd_ack; // pre-empted read retries next cycle
    assign ram_en    = wr_req || rd_grant;
    assign ram_we    = wr_req;
    assign ram_addr  = wr_req ? wr_addr : rd_addr;
    assign ram_wdata = wr_data;
    assign rd_data   = ram_rdata;                    // registered in the RAM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_grant;
        end
    end

    // requester keeps its read open and its address steady until the data returns
    a_req_held_to_ack: assert property (@(posedge clk) disable iff (!rst_n)
        rd_ack |-> rd_req && $stable(rd_addr));

endmodule

`default_nettype wire

/* logic/payload_ram.sv */
// read data appears one cycle after an enabled access and shows the old word on a write
`default_nettype none
`include "udp_rx_settings.svh"

module payload_ram (
    input  wire                        clk,
    input  wire                        en,
    input  wire                        we,
    input  wire udp_rx_pkg::buf_addr_t addr,
    input  wire udp_rx_pkg::word_t     wdata,
    output udp_rx_pkg::word_t          rdata
);

    udp_rx_pkg::word_t mem [`UDP_BUF_WORDS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* logic/axil_host_port.sv */
// full-word writes only, no strobes; one transaction per channel at a time and OKAY on every access
`default_nettype none
`include "udp_rx_settings.svh"

module axil_host_port (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire [`AXIL_ADDR_W-1:0]     awaddr,
    input  wire                        awvalid,
    output logic                       awready,
    input  wire udp_rx_pkg::word_t     wdata,
    input  wire                        wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  wire                        bready,
    input  wire [`AXIL_ADDR_W-1:0]     araddr,
    input  wire                        arvalid,
    output logic                       arready,
    output udp_rx_pkg::word_t          rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  wire                        rready,
    input  wire                        pkt_done,
    input  wire                        pkt_drop,
    input  wire udp_rx_pkg::byte_cnt_t pkt_bytes,
    input  wire                        rd_ack,
    input  wire udp_rx_pkg::word_t     rd_data,
    output logic                       buf_held,
    output logic                       rd_req,
    output udp_rx_pkg::buf_addr_t      rd_addr
);

    logic                    aw_hold;
    logic                    w_hold;
    logic [`AXIL_ADDR_W-1:0] aw_addr_q;
    udp_rx_pkg::word_t       w_data_q;
    udp_rx_pkg::byte_cnt_t   byte_cnt;
    udp_rx_pkg::byte_cnt_t   drops;
    udp_rx_pkg::word_t       reg_rdata;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    ar_fire;
    logic                    do_write;
    logic                    ar_payload;

    assign aw_fire    = awvalid && awready;
    assign w_fire     = wvalid && wready;
    assign ar_fire    = arvalid && arready;
    assign do_write   = aw_hold && w_hold && !bvalid;
    assign ar_payload = (araddr >= `PAYLOAD_BASE) &&
                        (araddr < `PAYLOAD_BASE + 4 * `UDP_BUF_WORDS);
    assign bresp      = 2'b00;
    assign rresp      = 2'b00;

    always_comb begin
        case (araddr)
            `REG_STATUS: reg_rdata = {byte_cnt, 15'd0, buf_held};
            `REG_DROPS:  reg_rdata = {16'd0, drops};
            default:     reg_rdata = '0;          // release and unmapped read as zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            arready  <= 1'b0;
            aw_hold  <= 1'b0;
            w_hold   <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            rd_req   <= 1'b0;
            buf_held <= 1'b0;
            byte_cnt <= '0;
            drops    <= '0;
        end else begin
            awready <= !aw_hold && !aw_fire && !bvalid;
            wready  <= !w_hold && !w_fire && !bvalid;
            arready <= !ar_fire && !rd_req && !rvalid; // next address after R handshake
            if (aw_fire) begin
                aw_hold <= 1'b1;
            end
            if (w_fire) begin
                w_hold <= 1'b1;
            end
            if (do_write) begin
                aw_hold <= 1'b0;
                w_hold  <= 1'b0;
                bvalid  <= 1'b1;
                if (aw_addr_q == `REG_RELEASE && w_data_q[0]) begin
                    buf_held <= 1'b0;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (pkt_done) begin
                buf_held <= 1'b1;
                byte_cnt <= pkt_bytes;
            end
            if (pkt_drop && drops != 16'hffff) begin
                drops <= drops + 16'd1;                // saturates
            end
            if (ar_fire) begin
                if (ar_payload) begin
                    rd_req <= 1'b1;
                end else begin
                    rvalid <= 1'b1;
                end
            end
            if (rd_ack) begin
                rd_req <= 1'b0;
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= awaddr;
        end
        if (w_fire) begin
            w_data_q <= wdata;
        end
        if (ar_fire) begin
            rd_addr <= araddr[2 +: $bits(udp_rx_pkg::buf_addr_t)]; // base aligned to window
            rdata   <= reg_rdata;
        end
        if (rd_ack) begin
            rdata <= rd_data;
        end
    end

    a_rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* logic/udp_rx_top.sv */
// local_mac and local_ip must stay static while frames arrive; the GMII side is never stalled
`default_nettype none
`include "udp_rx_settings.svh"

module udp_rx_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    gmii_rxdv,
    input  wire [7:0]              gmii_rxd,
    input  wire udp_rx_pkg::mac_t  local_mac,
    input  wire udp_rx_pkg::ip4_t  local_ip,
    input  wire [`AXIL_ADDR_W-1:0] awaddr,
    input  wire                    awvalid,
    output logic                   awready,
    input  wire udp_rx_pkg::word_t wdata,
    input  wire                    wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire                    bready,
    input  wire [`AXIL_ADDR_W-1:0] araddr,
    input  wire                    arvalid,
    output logic                   arready,
    output udp_rx_pkg::word_t      rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire                    rready
);

    logic                  wr_req;
    udp_rx_pkg::buf_addr_t wr_addr;
    udp_rx_pkg::word_t     wr_data;
    logic                  pkt_done;
    logic                  pkt_drop;
    udp_rx_pkg::byte_cnt_t pkt_bytes;
    logic                  buf_held;
    logic                  rd_req;
    udp_rx_pkg::buf_addr_t rd_addr;
    logic                  rd_ack;
    udp_rx_pkg::word_t     rd_data;
    logic                  ram_en;
    logic                  ram_we;
    udp_rx_pkg::buf_addr_t ram_addr;
    udp_rx_pkg::word_t     ram_wdata;
    udp_rx_pkg::word_t     ram_rdata;

    udp_rx_parser i_parser (.*);

    buf_arbiter i_arbiter (.*);

    payload_ram i_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    axil_host_port i_host (.*);

endmodule

`default_nettype wire

/* verif/udp_rx_tb.sv */
// frames go out back to back with a 12-byte gap, payloads stay below 1024 bytes, FCS bytes are filler
`default_nettype none
`include "udp_rx_settings.svh"

module udp_rx_tb;

    localparam int gap_bytes = 12;
    localparam udp_rx_pkg::mac_t own_mac = 48'h02_12_34_56_78_9a;
    localparam udp_rx_pkg::mac_t bcast   = 48'hffff_ffff_ffff;
    localparam udp_rx_pkg::ip4_t own_ip  = 32'hc0a8_0164;

    typedef struct packed {
        udp_rx_pkg::mac_t      dest_mac;
        logic [15:0]           ethertype;
        udp_rx_pkg::ip4_t      dest_ip;
        logic [3:0]            ihl;
        udp_rx_pkg::byte_cnt_t payload_len;
        logic                  preamble_ok;
        logic                  release_before;
        logic                  expect_stored;
    } frame_t;

    logic                    clk;
    logic                    rst_n;
    logic                    gmii_rxdv;
    logic [7:0]              gmii_rxd;
    udp_rx_pkg::mac_t        local_mac;
    udp_rx_pkg::ip4_t        local_ip;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    udp_rx_pkg::word_t       wdata;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    udp_rx_pkg::word_t       rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;

    frame_t                tbl[$];
    logic [7:0]            cur_pay[$];  // payload of the frame on the wire
    logic [7:0]            exp_pay[$];  // payload the buffer should hold
    logic [31:0]           rng_state;
    logic                  model_valid;
    udp_rx_pkg::byte_cnt_t model_cnt;
    udp_rx_pkg::byte_cnt_t model_drops;
    int                    errors;
    int                    checks;

    udp_rx_top i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_frame(input udp_rx_pkg::mac_t mac, input logic [15:0] etype,
                             input udp_rx_pkg::ip4_t ip, input logic [3:0] ihl,
                             input int len, input logic pre_ok, input logic rel,
                             input logic stored);
        frame_t f;
        f = {mac, etype, ip, ihl, 16'(len), pre_ok, rel, stored};
        tbl.push_back(f);
    endtask

    // big-endian packing, lanes past the payload end read as zero
    function automatic udp_rx_pkg::word_t expected_word(input int n);
        udp_rx_pkg::word_t w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            if (4 * n + k < exp_pay.size()) begin
                w[31 - 8 * k -: 8] = exp_pay[4 * n + k];
            end
        end
        return w;
    endfunction

    task automatic check_word(input logic [11:0] addr, input udp_rx_pkg::word_t got,
                              input udp_rx_pkg::word_t exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error: rdata at %h = %h, expected %h", addr, got, exp);
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input udp_rx_pkg::word_t data);
        logic aw_go;
        logic w_go;
        logic b_go;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (bready) begin
            aw_go = awvalid && awready; // ready is registered, stable until next posedge
            w_go  = wvalid && wready;
            b_go  = bvalid && bready;
            if (b_go) begin
                checks++;
                assert (bresp == 2'b00) else begin
                    errors++;
                    $display("Error: bresp = %h, expected 0", bresp);
                end
            end
            @(negedge clk);
            if (aw_go) awvalid = 1'b0;
            if (w_go) wvalid = 1'b0;
            if (b_go) bready = 1'b0;
        end
    endtask

    // stall holds rready low for that many cycles once rvalid is up
    task automatic axi_read(input logic [11:0] addr, input int stall,
                            output udp_rx_pkg::word_t data);
        logic ar_go;
        logic r_go;
        logic done;
        int   waited;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (stall == 0);
        done    = 1'b0;
        waited  = 0;
        data    = '0;
        while (!done) begin
            if (rvalid && !rready) begin
                if (waited >= stall) rready = 1'b1;
                waited++;
            end
            ar_go = arvalid && arready;
            r_go  = rvalid && rready;
            if (r_go) begin
                data = rdata;
                checks++;
                assert (rresp == 2'b00) else begin
                    errors++;
                    $display("Error: rresp = %h, expected 0", rresp);
                end
            end
            @(negedge clk);
            if (ar_go) arvalid = 1'b0;
            if (r_go) begin
                rready = 1'b0;
                done   = 1'b1;
            end
        end
    endtask

    task automatic send_frame(input frame_t f);
        logic [7:0]  fb[$];
        logic [7:0]  b;
        logic [15:0] ip_len;
        logic [15:0] udp_len;
        udp_len = f.payload_len + 16'd8;
        ip_len  = 16'(4 * f.ihl) + udp_len;
        for (int k = 0; k < 7; k++) fb.push_back(8'h55);
        fb.push_back(f.preamble_ok ? 8'hd5 : 8'hd4); // SFD
        for (int k = 0; k < 6; k++) fb.push_back(f.dest_mac[47 - 8 * k -: 8]);
        for (int k = 0; k < 6; k++) fb.push_back(8'h20 + 8'(k)); // source MAC
        fb.push_back(f.ethertype[15:8]);
        fb.push_back(f.ethertype[7:0]);
        for (int k = 0; k < 4 * f.ihl; k++) begin
            case (k)
                0:              b = {4'h4, f.ihl};
                2:              b = ip_len[15:8];
                3:              b = ip_len[7:0];
                8:              b = 8'd64;  // TTL
                9:              b = 8'd17;  // UDP
                12, 13, 14, 15: b = 8'h0a;
                16, 17, 18, 19: b = f.dest_ip[8 * (19 - k) +: 8];
                default:        b = (k >= 20) ? 8'h01 : 8'h00; // options as NOP
            endcase
            fb.push_back(b);
        end
        fb.push_back(8'h12);
        fb.push_back(8'h34);
        fb.push_back(8'h13);
        fb.push_back(8'h89);
        fb.push_back(udp_len[15:8]);
        fb.push_back(udp_len[7:0]);
        fb.push_back(8'h00);
        fb.push_back(8'h00);
        foreach (cur_pay[k]) fb.push_back(cur_pay[k]);
        repeat (4) fb.push_back(8'hee);  // FCS, not checked by the DUT
        foreach (fb[k]) begin
            @(negedge clk);
            gmii_rxdv = 1'b1;
            gmii_rxd  = fb[k];
        end
        @(negedge clk);
        gmii_rxdv = 1'b0;
        gmii_rxd  = 8'h00;
        repeat (gap_bytes) @(negedge clk);
    endtask

    task automatic check_payload();
        udp_rx_pkg::word_t got;
        logic [11:0]       addr;
        int                words;
        words = (exp_pay.size() + 3) / 4;
        if (words > `UDP_BUF_WORDS) words = `UDP_BUF_WORDS;
        for (int n = 0; n < words; n++) begin
            addr = `PAYLOAD_BASE + 12'(4 * n);
            axi_read(addr, (n % 3 == 1) ? 3 : 0, got); // every third read back-pressured
            check_word(addr, got, expected_word(n));
        end
    endtask

    task automatic check_status_regs();
        udp_rx_pkg::word_t got;
        axi_read(`REG_STATUS, 0, got);
        check_word(`REG_STATUS, got, {model_cnt, 15'd0, model_valid});
        axi_read(`REG_DROPS, 2, got);
        check_word(`REG_DROPS, got, {16'd0, model_drops});
    endtask

    initial begin
        longint limit;
        logic   passes;
        logic   store;
        frame_t f;
        clk         = 1'b0;
        rst_n       = 1'b0;
        gmii_rxdv   = 1'b0;
        gmii_rxd    = 8'h00;
        local_mac   = own_mac;
        local_ip    = own_ip;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        rng_state   = 32'h9ba6;
        model_valid = 1'b0;
        model_cnt   = '0;
        model_drops = '0;
        errors      = 0;
        checks      = 0;

        //        dest_mac  type     dest_ip          ihl len pre rel stored
        add_frame(own_mac, 16'h0800, own_ip,          5,  1,  1,  0,  1);
        add_frame(own_mac, 16'h0800, own_ip,          5,  37, 1,  1,  1);
        add_frame(bcast,   16'h0800, own_ip,          7,  64, 1,  1,  1);
        add_frame(own_mac ^ 48'h1, 16'h0800, own_ip,  5,  16, 1,  1,  0);
        add_frame(own_mac, 16'h86dd, own_ip,          5,  16, 1,  0,  0);
        add_frame(own_mac, 16'h0800, 32'hc0a8_0165,   5,  16, 1,  0,  0);
        add_frame(own_mac, 16'h0800, own_ip,          5,  16, 0,  0,  0);
        add_frame(own_mac, 16'h0800, own_ip,          5,  20, 1,  0,  1);
        add_frame(own_mac, 16'h0800, own_ip,          5,  9,  1,  0,  0);
        add_frame(bcast,   16'h0800, own_ip,          6,  5,  1,  0,  0);
        add_frame(own_mac, 16'h0800, own_ip,          5,  48, 1,  1,  1);

        limit = 0;
        foreach (tbl[i]) begin
            limit += 8 + 14 + 4 * tbl[i].ihl + 8 + tbl[i].payload_len + 4 + gap_bytes + 400;
        end
        limit *= 40;
        fork
            begin : watchdog
                udp_rx_pkg::rx_state_t st;
                #(limit);
                st = i_dut.i_parser.state;
                $display("Timeout: run did not finish in %0d time units, parser state %s",
                         limit, st.name());
                $display("Simulation failed");
                $finish;
            end
        join_none

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        foreach (tbl[i]) begin
            f = tbl[i];
            if (f.release_before) begin
                axi_write(`REG_RELEASE, 32'h1);
                model_valid = 1'b0;
            end
            cur_pay.delete();
            for (int k = 0; k < f.payload_len; k++) begin
                rng_state = lcg_next(rng_state);
                cur_pay.push_back(rng_state[23:16]);
            end
            passes = (f.dest_mac == own_mac || f.dest_mac == bcast) &&
                     f.ethertype == `ETH_TYPE_IPV4 && f.dest_ip == own_ip &&
                     f.preamble_ok && f.ihl >= 4'd5;
            store  = passes && !model_valid;
            checks++;
            assert (store == f.expect_stored) else begin
                errors++;
                $display("table entry %0d expects a result the filter rules do not give", i);
            end
            if (model_valid) begin
                fork
                    send_frame(f);
                    check_payload(); // held buffer read while the frame arrives
                join
            end else begin
                send_frame(f);
            end
            if (store) begin
                model_valid = 1'b1;
                model_cnt   = f.payload_len;
                exp_pay     = cur_pay;
            end else if (passes && model_drops != 16'hffff) begin
                model_drops++;
            end
            check_status_regs();
            if (model_valid) check_payload();
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/udp_rx_pkg.sv
udp_rx/udp_rx_parser.sv
logic/buf_arbiter.sv
logic/payload_ram.sv
logic/axil_host_port.sv
logic/udp_rx_top.sv
verif/udp_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= udp_rx_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "test FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
